// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= tb_sound_glue
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== design/audio_mixer.sv ====
`default_nettype none

module audio_mixer (
  input  logic                     fclk,
  input  logic                     rst_n,
  input  sound_pkg::chip_samples_t samples,
  input  logic                     beeper,
  input  sound_pkg::covox_t [1:0]  covox_l,
  input  sound_pkg::covox_t [1:0]  covox_r,
  output sound_pkg::sample_t       audio_l,
  output sound_pkg::sample_t       audio_r
);

  // One side of the mix, all terms aligned to 12 bits, sum wraps
  function automatic sound_pkg::sample_t mix_side(
    input sound_pkg::sample_t    ts,
    input sound_pkg::gs_sample_t gs,
    input sound_pkg::covox_t     cov_a,
    input sound_pkg::covox_t     cov_b,
    input sound_pkg::covox_t     saa,
    input logic                  beep
  );
    sound_pkg::sample_t gs_term;
    sound_pkg::sample_t cov_a_term;
    sound_pkg::sample_t cov_b_term;
    sound_pkg::sample_t saa_term;
    sound_pkg::sample_t beep_term;
    // GS keeps its sign, drops the 4 low bits
    gs_term    = {gs[sound_pkg::gs_sample_w-1], gs[sound_pkg::gs_sample_w-1:4]};
    cov_a_term = sound_pkg::sample_t'(cov_a) << sound_pkg::covox_shift;
    cov_b_term = sound_pkg::sample_t'(cov_b) << sound_pkg::covox_shift;
    saa_term   = sound_pkg::sample_t'(saa) << sound_pkg::saa_shift;
    beep_term  = sound_pkg::sample_t'(beep) << sound_pkg::beeper_shift;
    return ts + gs_term + cov_a_term + cov_b_term + saa_term + beep_term;
  endfunction

  always_ff @(posedge fclk) begin
    if (!rst_n) begin
      audio_l <= '0;
      audio_r <= '0;
    end else begin
      audio_l <= mix_side(samples.ts_l, samples.gs_l, covox_l[0], covox_l[1],
                          samples.saa_l, beeper);
      audio_r <= mix_side(samples.ts_r, samples.gs_r, covox_r[0], covox_r[1],
                          samples.saa_r, beeper);
    end
  end

endmodule

`default_nettype wire

// ==== design/chip_ce_gen.sv ====
`default_nettype none

module chip_ce_gen (
  input  logic fclk,
  input  logic rst_n,
  output logic ce_ym,
  output logic ce_saa
);

  sound_pkg::ym_cnt_t  ym_cnt;
  sound_pkg::saa_cnt_t saa_cnt;

  // YM divider wraps on its own width
  always_ff @(posedge fclk) begin
    if (!rst_n) begin
      ym_cnt <= '0;
      ce_ym  <= 1'b0;
    end else begin
      ym_cnt <= ym_cnt + 1'b1;
      ce_ym  <= (ym_cnt == '0);
    end
  end

  // Two pulses per seven cycles, uneven spacing
  always_ff @(posedge fclk) begin
    if (!rst_n) begin
      saa_cnt <= '0;
      ce_saa  <= 1'b0;
    end else begin
      if (saa_cnt == sound_pkg::saa_cnt_t'(sound_pkg::saa_div - 1)) begin
        saa_cnt <= '0;
      end else begin
        saa_cnt <= saa_cnt + 1'b1;
      end
      ce_saa <= (saa_cnt == '0)
             || (saa_cnt == sound_pkg::saa_cnt_t'(sound_pkg::saa_phase_b));
    end
  end

endmodule

`default_nettype wire

// ==== design/sound_glue_top.sv ====
`default_nettype none

module sound_glue_top (
  input  logic                     fclk,
  input  logic                     rst_n,
  input  sound_pkg::zbus_t         bus,
  input  logic                     dos,
  input  sound_pkg::chip_samples_t samples,
  input  sound_pkg::zdata_t        ts_rdata,
  input  sound_pkg::zdata_t        gs_rdata,
  output sound_pkg::zdata_t        rdata,
  output sound_pkg::chip_ctrl_t    ctrl,
  output logic                     ce_ym,
  output logic                     ce_saa,
  output sound_pkg::sample_t       audio_l,
  output sound_pkg::sample_t       audio_r
);

  sound_pkg::reg_wr_t      reg_wr;
  logic                    beeper;
  sound_pkg::covox_t [1:0] covox_l;
  sound_pkg::covox_t [1:0] covox_r;

  zbus_decode i_decode (
    .bus      (bus),
    .dos      (dos),
    .ts_rdata (ts_rdata),
    .gs_rdata (gs_rdata),
    .ctrl     (ctrl),
    .reg_wr   (reg_wr),
    .rdata    (rdata)
  );

  chip_ce_gen i_ce_gen (
    .fclk   (fclk),
    .rst_n  (rst_n),
    .ce_ym  (ce_ym),
    .ce_saa (ce_saa)
  );

  // Beeper and Soundrive latches feeding the mixer
  sound_port_regs i_port_regs (
    .fclk    (fclk),
    .rst_n   (rst_n),
    .reg_wr  (reg_wr),
    .beeper  (beeper),
    .covox_l (covox_l),
    .covox_r (covox_r)
  );

  audio_mixer i_mixer (
    .fclk    (fclk),
    .rst_n   (rst_n),
    .samples (samples),
    .beeper  (beeper),
    .covox_l (covox_l),
    .covox_r (covox_r),
    .audio_l (audio_l),
    .audio_r (audio_r)
  );

endmodule

`default_nettype wire

// ==== design/sound_pkg.sv ====
`default_nettype none

package sound_pkg;

  // Bus and sample widths, fixed by the CPU and the sound chips
  localparam int zaddr_w     = 16;
  localparam int zdata_w     = 8;
  localparam int sample_w    = 12;
  localparam int gs_sample_w = 15;
  localparam int covox_w     = 8;

  typedef logic [zaddr_w-1:0]     zaddr_t;
  typedef logic [zdata_w-1:0]     zdata_t;
  typedef logic [sample_w-1:0]    sample_t;
  typedef logic [gs_sample_w-1:0] gs_sample_t;
  typedef logic [covox_w-1:0]     covox_t;

  // Soundrive ports, low address byte
  localparam zdata_t covox_port_a = 8'h0F;
  localparam zdata_t covox_port_b = 8'h1F;
  localparam zdata_t covox_port_c = 8'h4F;
  localparam zdata_t covox_port_d = 8'h5F;

  localparam zdata_t     saa_port   = 8'hFF;
  localparam logic [3:0] gs_port_hi = 4'hB;
  localparam logic [2:0] gs_port_lo = 3'd3;
  localparam int         beeper_bit = 4;

  // Chip clock enable dividers
  localparam int ym_div      = 8;
  localparam int saa_div     = 7;
  localparam int saa_phase_b = 3;

  typedef logic [$clog2(ym_div)-1:0]  ym_cnt_t;
  typedef logic [$clog2(saa_div)-1:0] saa_cnt_t;

  // Mixer alignment
  localparam int covox_shift  = 2;
  localparam int saa_shift    = 3;
  localparam int beeper_shift = 8;

  localparam zdata_t bus_idle = 8'hFF;

  typedef struct packed {
    zaddr_t addr;
    zdata_t wdata;
    logic   iorq_n;
    logic   m1_n;
    logic   rd_n;
    logic   wr_n;
  } zbus_t;

  typedef struct packed {
    sample_t    ts_l;
    sample_t    ts_r;
    gs_sample_t gs_l;
    gs_sample_t gs_r;
    covox_t     saa_l;
    covox_t     saa_r;
  } chip_samples_t;

  typedef struct packed {
    logic ts_we;
    logic ts_bc;
    logic gs_cs_n;
    logic gs_a;
    logic saa_wr_n;
    logic saa_a0;
  } chip_ctrl_t;

  // covox_wr bit 0 is channel a, bit 3 is channel d
  typedef struct packed {
    logic       beeper_wr;
    logic [3:0] covox_wr;
    zdata_t     wdata;
  } reg_wr_t;

endpackage

`default_nettype wire

// ==== design/sound_port_regs.sv ====
`default_nettype none

module sound_port_regs (
  input  logic                      fclk,
  input  logic                      rst_n,
  input  sound_pkg::reg_wr_t        reg_wr,
  output logic                      beeper,
  output sound_pkg::covox_t [1:0]   covox_l,
  output sound_pkg::covox_t [1:0]   covox_r
);

  // Channels a..d, same order as covox_wr
  sound_pkg::covox_t [3:0] covox_q;

  always_ff @(posedge fclk) begin
    if (!rst_n) begin
      beeper <= 1'b0;
    end else if (reg_wr.beeper_wr) begin
      beeper <= reg_wr.wdata[sound_pkg::beeper_bit];
    end
  end

  always_ff @(posedge fclk) begin
    if (!rst_n) begin
      covox_q <= '0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (reg_wr.covox_wr[i]) begin
          covox_q[i] <= reg_wr.wdata;
        end
      end
    end
  end

  // a,b to the left side and c,d to the right
  assign covox_l = covox_q[1:0];
  assign covox_r = covox_q[3:2];

endmodule

`default_nettype wire

// ==== design/zbus_decode.sv ====
`default_nettype none

module zbus_decode (
  input  sound_pkg::zbus_t      bus,
  input  logic                  dos,
  input  sound_pkg::zdata_t     ts_rdata,
  input  sound_pkg::zdata_t     gs_rdata,
  output sound_pkg::chip_ctrl_t ctrl,
  output sound_pkg::reg_wr_t    reg_wr,
  output sound_pkg::zdata_t     rdata
);

  logic              io_wr;
  logic              io_rd;
  logic              ts_en;
  logic              gs_sel;
  logic              saa_hit;
  sound_pkg::zdata_t lo_byte;

  assign lo_byte = bus.addr[7:0];

  assign io_wr = ~bus.iorq_n & ~bus.wr_n;
  assign io_rd = ~bus.iorq_n & ~bus.rd_n;

  // TurboSound answers on A15=1, A1=0, A0=1 (BFFD / FFFD family)
  assign ts_en = ~bus.iorq_n & bus.addr[15] & ~bus.addr[1] & bus.addr[0];

  // General Sound at xxB3 / xxBB, not during interrupt acknowledge
  assign gs_sel = ~bus.iorq_n & bus.m1_n
                & (bus.addr[7:4] == sound_pkg::gs_port_hi)
                & (bus.addr[2:0] == sound_pkg::gs_port_lo);

  // SAA shares xxFF with the floppy controller, so it hides under DOS
  assign saa_hit = io_wr & ~dos & (lo_byte == sound_pkg::saa_port);

  always_comb begin
    ctrl.ts_we    = ts_en & ~bus.wr_n;
    ctrl.ts_bc    = bus.addr[14];
    ctrl.gs_cs_n  = ~gs_sel;
    ctrl.gs_a     = bus.addr[3];
    ctrl.saa_wr_n = ~saa_hit;
    ctrl.saa_a0   = bus.addr[8];
  end

  always_comb begin
    reg_wr.beeper_wr   = io_wr & ~bus.addr[0];
    reg_wr.covox_wr[0] = io_wr & ~dos & (lo_byte == sound_pkg::covox_port_a);
    reg_wr.covox_wr[1] = io_wr & ~dos & (lo_byte == sound_pkg::covox_port_b);
    reg_wr.covox_wr[2] = io_wr & ~dos & (lo_byte == sound_pkg::covox_port_c);
    reg_wr.covox_wr[3] = io_wr & ~dos & (lo_byte == sound_pkg::covox_port_d);
    reg_wr.wdata       = bus.wdata;
  end

  // GS has priority over TurboSound on a read
  always_comb begin
    if (gs_sel && io_rd) begin
      rdata = gs_rdata;
    end else if (ts_en && io_rd) begin
      rdata = ts_rdata;
    end else begin
      rdata = sound_pkg::bus_idle;
    end
  end

endmodule

`default_nettype wire

// ==== project.f ====
design/sound_pkg.sv
design/zbus_decode.sv
design/chip_ce_gen.sv
design/sound_port_regs.sv
design/audio_mixer.sv
design/sound_glue_top.sv
verification/sound_glue_asserts.sv
verification/tb_sound_glue.sv

// ==== verification/sound_glue_asserts.sv ====
`default_nettype none

module sound_glue_asserts (
  input wire logic                  fclk,
  input wire logic                  rst_n,
  input wire logic                  dos,
  input wire logic                  ce_ym,
  input wire sound_pkg::chip_ctrl_t ctrl,
  input wire sound_pkg::reg_wr_t    reg_wr
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;

  // YM enable is one cycle in eight
  property ym_spacing;
    @(posedge fclk) disable iff (!rst_n)
      ce_ym |=> !ce_ym [*7];
  endproperty

  property no_ts_gs_clash;
    @(posedge fclk) disable iff (!rst_n)
      !(ctrl.ts_we && !ctrl.gs_cs_n);
  endproperty

  // Floppy controller owns xxFF and the covox range under DOS
  property dos_blocks_writes;
    @(posedge fclk) disable iff (!rst_n)
      dos |-> (ctrl.saa_wr_n && (reg_wr.covox_wr == 4'b0000));
  endproperty

  a_ym_spacing: assert property (ym_spacing)
    else begin
      fail_cnt++;
      $error("ce_ym pulse not followed by 7 low cycles");
    end

  a_no_ts_gs_clash: assert property (no_ts_gs_clash)
    else begin
      fail_cnt++;
      $error("TurboSound write and GS select active together");
    end

  a_dos_blocks_writes: assert property (dos_blocks_writes)
    else begin
      fail_cnt++;
      $error("SAA or covox write strobe active while dos is high");
    end

endmodule

bind sound_glue_top sound_glue_asserts i_asserts (
  .fclk   (fclk),
  .rst_n  (rst_n),
  .dos    (dos),
  .ce_ym  (ce_ym),
  .ctrl   (ctrl),
  .reg_wr (reg_wr)
);

`default_nettype wire

// ==== verification/tb_sound_glue.sv ====
`default_nettype none

module tb_sound_glue;
  timeunit 1ns;
  timeprecision 100ps;

  typedef struct packed {
    sound_pkg::zaddr_t     addr;
    sound_pkg::zdata_t     wdata;
    logic [1:0]            op;
    logic                  dos;
    sound_pkg::zdata_t     ts_rdata;
    sound_pkg::zdata_t     gs_rdata;
    sound_pkg::chip_ctrl_t exp_ctrl;
    sound_pkg::zdata_t     exp_rdata;
  } row_t;

  localparam logic [1:0] op_wr  = 2'd1;
  localparam logic [1:0] op_rd  = 2'd2;
  // Interrupt acknowledge drives iorq and m1 low
  localparam logic [1:0] op_ack = 2'd3;

  logic                     fclk;
  logic                     rst_n;
  sound_pkg::zbus_t         bus;
  logic                     dos;
  sound_pkg::chip_samples_t samples;
  sound_pkg::zdata_t        ts_rdata;
  sound_pkg::zdata_t        gs_rdata;
  sound_pkg::zdata_t        rdata;
  sound_pkg::chip_ctrl_t    ctrl;
  logic                     ce_ym;
  logic                     ce_saa;
  sound_pkg::sample_t       audio_l;
  sound_pkg::sample_t       audio_r;

  row_t                     stim_q[$];
  integer                   seed;
  logic                     sh_beeper;
  sound_pkg::covox_t [3:0]  sh_covox;

  sound_glue_top i_dut (
    .fclk     (fclk),
    .rst_n    (rst_n),
    .bus      (bus),
    .dos      (dos),
    .samples  (samples),
    .ts_rdata (ts_rdata),
    .gs_rdata (gs_rdata),
    .rdata    (rdata),
    .ctrl     (ctrl),
    .ce_ym    (ce_ym),
    .ce_saa   (ce_saa),
    .audio_l  (audio_l),
    .audio_r  (audio_r)
  );

  initial begin
    fclk = 1'b0;
    forever #20 fclk = ~fclk;
  end

  task automatic stop_on_error();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_ctrl(input string name, input sound_pkg::chip_ctrl_t got,
                            input sound_pkg::chip_ctrl_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_byte(input string name, input sound_pkg::zdata_t got,
                            input sound_pkg::zdata_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_sample(input string name, input sound_pkg::sample_t got,
                              input sound_pkg::sample_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      stop_on_error();
    end
  endtask

  // Expected mix of one side, wraps at 4096
  function automatic sound_pkg::sample_t expect_mix(
    input sound_pkg::sample_t    ts,
    input sound_pkg::gs_sample_t gs,
    input sound_pkg::covox_t     ca,
    input sound_pkg::covox_t     cb,
    input sound_pkg::covox_t     saa,
    input logic                  beep
  );
    int acc;
    int gs_s;
    gs_s = int'($signed(gs)) >>> 4;
    acc  = int'(ts) + gs_s;
    acc  = acc + (int'(ca) << sound_pkg::covox_shift) + (int'(cb) << sound_pkg::covox_shift);
    acc  = acc + (int'(saa) << sound_pkg::saa_shift);
    acc  = acc + (beep ? (1 << sound_pkg::beeper_shift) : 0);
    return sound_pkg::sample_t'(acc & 'hFFF);
  endfunction

  task automatic add_row(input sound_pkg::zaddr_t addr, input sound_pkg::zdata_t wdata,
                         input logic [1:0] op, input logic dos_lvl,
                         input logic [5:0] exp_ctrl, input sound_pkg::zdata_t exp_rdata);
    row_t r;
    r = '{addr, wdata, op, dos_lvl, 8'h5A, 8'hC3, exp_ctrl, exp_rdata};
    stim_q.push_back(r);
  endtask

  task automatic drive_idle_bus();
    bus = '{addr: '0, wdata: '0, iorq_n: 1'b1, m1_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1};
  endtask

  task automatic randomize_samples();
    samples.ts_l  = sound_pkg::sample_t'($random(seed));
    samples.ts_r  = sound_pkg::sample_t'($random(seed));
    samples.gs_l  = sound_pkg::gs_sample_t'($random(seed));
    samples.gs_r  = sound_pkg::gs_sample_t'($random(seed));
    samples.saa_l = sound_pkg::covox_t'($random(seed));
    samples.saa_r = sound_pkg::covox_t'($random(seed));
  endtask

  task automatic check_audio();
    check_sample("audio_l", audio_l, expect_mix(samples.ts_l, samples.gs_l, sh_covox[0],
                 sh_covox[1], samples.saa_l, sh_beeper));
    check_sample("audio_r", audio_r, expect_mix(samples.ts_r, samples.gs_r, sh_covox[2],
                 sh_covox[3], samples.saa_r, sh_beeper));
  endtask

  // Shadow of the port registers after a write edge
  task automatic update_shadow(input row_t r);
    if (r.op == op_wr) begin
      if (!r.addr[0]) begin
        sh_beeper = r.wdata[sound_pkg::beeper_bit];
      end
      if (!r.dos) begin
        case (r.addr[7:0])
          sound_pkg::covox_port_a: sh_covox[0] = r.wdata;
          sound_pkg::covox_port_b: sh_covox[1] = r.wdata;
          sound_pkg::covox_port_c: sh_covox[2] = r.wdata;
          sound_pkg::covox_port_d: sh_covox[3] = r.wdata;
          default: ;
        endcase
      end
    end
  endtask

  task automatic apply_row(input row_t r);
    @(posedge fclk);
    #5;
    bus = '{addr: r.addr, wdata: r.wdata, iorq_n: 1'b0, m1_n: (r.op != op_ack),
            rd_n: (r.op != op_rd), wr_n: (r.op != op_wr)};
    dos      = r.dos;
    ts_rdata = r.ts_rdata;
    gs_rdata = r.gs_rdata;
    randomize_samples();
    #10;
    check_ctrl("ctrl", ctrl, r.exp_ctrl);
    check_byte("rdata", rdata, r.exp_rdata);
    @(posedge fclk);
    #5;
    drive_idle_bus();
    update_shadow(r);
    @(posedge fclk);
    #1;
    check_audio();
  endtask

  task automatic load_table();
    // addr, wdata, op, dos, ctrl {ts_we,ts_bc,gs_cs_n,gs_a,saa_wr_n,saa_a0}, rdata
    add_row(16'hFFFD, 8'h07, op_wr, 1'b0, 6'b111111, 8'hFF);
    add_row(16'hBFFD, 8'h3C, op_wr, 1'b0, 6'b101111, 8'hFF);
    add_row(16'hFFFD, 8'h00, op_rd, 1'b0, 6'b011111, 8'h5A);
    add_row(16'h00B3, 8'h00, op_rd, 1'b0, 6'b000010, 8'hC3);
    add_row(16'h00BB, 8'h00, op_rd, 1'b0, 6'b000110, 8'hC3);
    add_row(16'h00BB, 8'h11, op_wr, 1'b0, 6'b000110, 8'hFF);
    add_row(16'h80B3, 8'h00, op_rd, 1'b0, 6'b000010, 8'hC3);
    add_row(16'h00B3, 8'h00, op_ack, 1'b0, 6'b001010, 8'hFF);
    add_row(16'h001F, 8'h00, op_rd, 1'b0, 6'b001110, 8'hFF);
    add_row(16'h000F, 8'h80, op_wr, 1'b0, 6'b001110, 8'hFF);
    add_row(16'h001F, 8'hFF, op_wr, 1'b0, 6'b001110, 8'hFF);
    add_row(16'h004F, 8'h7E, op_wr, 1'b0, 6'b001110, 8'hFF);
    add_row(16'h005F, 8'hC0, op_wr, 1'b0, 6'b001110, 8'hFF);
    add_row(16'h00FE, 8'h10, op_wr, 1'b0, 6'b001110, 8'hFF);
    add_row(16'h01FF, 8'h22, op_wr, 1'b0, 6'b001101, 8'hFF);
    add_row(16'h00FF, 8'h22, op_wr, 1'b0, 6'b001100, 8'hFF);
    // DOS active, SAA and covox hidden
    add_row(16'h000F, 8'h55, op_wr, 1'b1, 6'b001110, 8'hFF);
    add_row(16'h01FF, 8'h33, op_wr, 1'b1, 6'b001111, 8'hFF);
    add_row(16'h00FE, 8'h00, op_wr, 1'b1, 6'b001110, 8'hFF);
    add_row(16'h00FE, 8'hFF, op_wr, 1'b0, 6'b001110, 8'hFF);
    add_row(16'h00FE, 8'h00, op_rd, 1'b0, 6'b001110, 8'hFF);
    add_row(16'h7FFD, 8'h10, op_wr, 1'b0, 6'b011111, 8'hFF);
    add_row(16'h005F, 8'hFF, op_wr, 1'b0, 6'b001110, 8'hFF);
  endtask

  task automatic check_enables();
    int ym_cnt;
    int saa_cnt;
    ym_cnt  = 0;
    saa_cnt = 0;
    for (int i = 0; i < 56; i++) begin
      @(posedge fclk);
      #1;
      check_bit("ce_ym", ce_ym, (i % 8) == 0);
      check_bit("ce_saa", ce_saa, ((i % 7) == 0) || ((i % 7) == 3));
      ym_cnt  += int'(ce_ym);
      saa_cnt += int'(ce_saa);
    end
    check_byte("ce_ym pulses", sound_pkg::zdata_t'(ym_cnt), 8'd7);
    check_byte("ce_saa pulses", sound_pkg::zdata_t'(saa_cnt), 8'd16);
  endtask

  initial begin
    seed      = 32'hc7f3_45bd;
    rst_n     = 1'b0;
    dos       = 1'b0;
    ts_rdata  = '0;
    gs_rdata  = '0;
    samples   = '0;
    sh_beeper = 1'b0;
    sh_covox  = '0;
    drive_idle_bus();
    load_table();
    repeat (3) @(posedge fclk);
    #1;
    check_bit("ce_ym", ce_ym, 1'b0);
    check_bit("ce_saa", ce_saa, 1'b0);
    #4;
    rst_n = 1'b1;
    check_enables();
    foreach (stim_q[i]) begin
      apply_row(stim_q[i]);
    end
    // Reset in mid-run
    @(posedge fclk);
    #5;
    rst_n = 1'b0;
    @(posedge fclk);
    #1;
    check_sample("audio_l", audio_l, '0);
    check_sample("audio_r", audio_r, '0);
    check_bit("ce_ym", ce_ym, 1'b0);
    check_bit("ce_saa", ce_saa, 1'b0);
    #4;
    rst_n     = 1'b1;
    sh_beeper = 1'b0;
    sh_covox  = '0;
    @(posedge fclk);
    #1;
    check_audio();
    if (i_dut.i_asserts.fail_cnt != 0) begin
      $display("bound assertion failed %0d times", i_dut.i_asserts.fail_cnt);
      stop_on_error();
    end else begin
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire
